// ==== design/mem_settings.svh ====
// sizing of the data memory path; include wherever widths, depth or latency are needed
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data word width in bits
`define MEM_XLEN 64

// byte address width
`define MEM_AW 32

// ram depth in words, power of two
`define MEM_WORDS 256

`define MEM_LATENCY 3 // accept to response valid, at least 1

`endif

// ==== design/lsu_pkg.sv ====
// pipeline side types of the load/store stage; import wherever a request or word is handled
`include "mem_settings.svh"

package lsu_pkg;

  typedef logic [`MEM_XLEN-1:0] xlen_t;
  typedef logic [`MEM_AW-1:0]   addr_t;

  // log2 of bytes: 0 byte .. 3 doubleword
  typedef logic [1:0] lsu_size_t;

  typedef struct packed {
    logic      is_store;
    logic      sign_ext; // loads only
    lsu_size_t size;
    addr_t     addr;
    xlen_t     wdata;    // store bytes sit at the bottom
  } lsu_req_t;

  typedef enum logic [2:0] {
    IDLE,
    WR_REQ,
    WR_RESP,
    RD_REQ,
    RD_DATA
  } lsu_state_e;

endpackage

// ==== design/bus_pkg.sv ====
// memory bus payload types shared by the access stage and the data ram
`include "mem_settings.svh"

package bus_pkg;
  import lsu_pkg::*;

  typedef logic [`MEM_XLEN/8-1:0] strb_t; // one bit per byte lane

  typedef struct packed {
    addr_t addr; // word aligned, low bits zero
    xlen_t data;
    strb_t strb;
  } bus_wreq_t;

  typedef struct packed {
    addr_t addr;
  } bus_rreq_t;

  // whole word, the stage picks the bytes
  typedef struct packed {
    xlen_t data;
  } bus_rdata_t;

endpackage

// ==== design/mem_access_stage.sv ====
// memory access stage that turns one pipeline load/store into bus transfers and stalls until done
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_access_stage
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  // pipeline side
  input  logic       req_valid_i,
  input  lsu_req_t   req_i,
  output logic       busy_o,
  output logic       done_o,
  output xlen_t      rdata_o,
  // write request and response
  output logic       wreq_valid_o,
  output bus_wreq_t  wreq_o,
  input  logic       wreq_ready_i,
  input  logic       bresp_valid_i,
  output logic       bresp_ready_o,
  // read request and data
  output logic       rreq_valid_o,
  output bus_rreq_t  rreq_o,
  input  logic       rreq_ready_i,
  input  logic       rdata_valid_i,
  input  bus_rdata_t rdata_i,
  output logic       rdata_ready_o
);

  lsu_state_e state_q;
  logic       taken_q; // set once the response is taken
  logic       accept;
  logic [2:0] off;
  strb_t      strb_base;

  // kept for the load return path
  logic [2:0] off_q;
  lsu_size_t  size_q;
  logic       sext_q;
  xlen_t      rword_q;
  xlen_t      shifted;
  xlen_t      ext;

  assign busy_o = (state_q != IDLE);
  assign accept = req_valid_i && !busy_o;
  assign off    = req_i.addr[2:0];

  assign wreq_valid_o  = (state_q == WR_REQ);
  assign rreq_valid_o  = (state_q == RD_REQ);
  assign bresp_ready_o = (state_q == WR_RESP) && !taken_q;
  assign rdata_ready_o = (state_q == RD_DATA) && !taken_q;

  always_comb begin
    case (req_i.size)
      2'd0:    strb_base = 8'h01;
      2'd1:    strb_base = 8'h03;
      2'd2:    strb_base = 8'h0f;
      default: strb_base = 8'hff;
    endcase
  end

  // pick the addressed bytes, then extend
  always_comb begin
    shifted = rword_q >> {off_q, 3'b000};
    case (size_q)
      2'd0:    ext = sext_q ? {{56{shifted[7]}}, shifted[7:0]} : {56'd0, shifted[7:0]};
      2'd1:    ext = sext_q ? {{48{shifted[15]}}, shifted[15:0]} : {48'd0, shifted[15:0]};
      2'd2:    ext = sext_q ? {{32{shifted[31]}}, shifted[31:0]} : {32'd0, shifted[31:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      taken_q <= 1'b0;
      done_o  <= 1'b0;
      rdata_o <= '0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= req_i.is_store ? WR_REQ : RD_REQ;
          end
        end
        WR_REQ: begin
          if (wreq_ready_i) state_q <= WR_RESP;
        end
        WR_RESP: begin
          if (taken_q) begin
            state_q <= IDLE;
            taken_q <= 1'b0;
            done_o  <= 1'b1;
          end else if (bresp_valid_i) begin
            taken_q <= 1'b1;
          end
        end
        RD_REQ: begin
          if (rreq_ready_i) state_q <= RD_DATA;
        end
        RD_DATA: begin
          if (taken_q) begin
            state_q <= IDLE;
            taken_q <= 1'b0;
            done_o  <= 1'b1;
            rdata_o <= ext; // holds until the next load
          end else if (rdata_valid_i) begin
            taken_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // payloads load once per access and hold through the handshakes
  always_ff @(posedge clk) begin
    if (accept) begin
      wreq_o.addr <= {req_i.addr[`MEM_AW-1:3], 3'b000};
      wreq_o.data <= req_i.wdata << {off, 3'b000};
      wreq_o.strb <= strb_base << off;
      rreq_o.addr <= {req_i.addr[`MEM_AW-1:3], 3'b000};
      off_q       <= off;
      size_q      <= req_i.size;
      sext_q      <= req_i.sign_ext;
    end
    if (rdata_valid_i && rdata_ready_o) begin
      rword_q <= rdata_i.data;
    end
  end

endmodule

// ==== design/data_ram.sv ====
// bus attached data ram: strobed writes, fixed latency responses held until taken
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_ram
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       wreq_valid_i,
  input  bus_wreq_t  wreq_i,
  output logic       wreq_ready_o,
  output logic       bresp_valid_o,
  input  logic       bresp_ready_i,
  input  logic       rreq_valid_i,
  input  bus_rreq_t  rreq_i,
  output logic       rreq_ready_o,
  output logic       rdata_valid_o,
  output bus_rdata_t rdata_o,
  input  logic       rdata_ready_i
);

  localparam int idx_w = $clog2(`MEM_WORDS);
  localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_RESP
  } ram_state_e;

  ram_state_e       state_q;
  logic             is_wr_q; // response kind
  logic [cnt_w-1:0] cnt_q;
  xlen_t            mem_q [`MEM_WORDS];

  logic             wr_hs;
  logic             rd_hs;
  logic             resp_hs;
  logic [idx_w-1:0] widx;
  logic [idx_w-1:0] ridx;

  assign wreq_ready_o = (state_q == RAM_IDLE);
  assign rreq_ready_o = (state_q == RAM_IDLE) && !wreq_valid_i; // write goes first

  assign wr_hs = wreq_valid_i && wreq_ready_o;
  assign rd_hs = rreq_valid_i && rreq_ready_o;

  assign bresp_valid_o = (state_q == RAM_RESP) && is_wr_q;
  assign rdata_valid_o = (state_q == RAM_RESP) && !is_wr_q;
  assign resp_hs = (bresp_valid_o && bresp_ready_i) || (rdata_valid_o && rdata_ready_i);

  // word index wraps at the depth
  assign widx = wreq_i.addr[3 +: idx_w];
  assign ridx = rreq_i.addr[3 +: idx_w];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= RAM_IDLE;
      is_wr_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RAM_IDLE: begin
          if (wr_hs || rd_hs) begin
            state_q <= RAM_WAIT;
            is_wr_q <= wr_hs;
            cnt_q   <= cnt_w'(`MEM_LATENCY - 1);
          end
        end
        RAM_WAIT: begin
          if (cnt_q == '0) state_q <= RAM_RESP;
          else             cnt_q <= cnt_q - 1'b1;
        end
        RAM_RESP: begin
          if (resp_hs) state_q <= RAM_IDLE;
        end
        default: state_q <= RAM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (wreq_i.strb[b]) mem_q[widx][8*b +: 8] <= wreq_i.data[8*b +: 8];
      end
    end
    if (rd_hs) begin
      rdata_o.data <= mem_q[ridx]; // held through the wait
    end
  end

endmodule

// ==== design/mem_subsys_top.sv ====
// memory subsystem top: access stage in front of the data ram, seen by the pipeline
`timescale 1ns/1ps

module mem_subsys_top
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  input  logic     req_valid_i,
  input  lsu_req_t req_i,
  output logic     busy_o,
  output logic     done_o,
  output xlen_t    rdata_o
);

  // write channel pair
  logic       wreq_valid;
  bus_wreq_t  wreq;
  logic       wreq_ready;
  logic       bresp_valid;
  logic       bresp_ready;

  // read channel pair
  logic       rreq_valid;
  bus_rreq_t  rreq;
  logic       rreq_ready;
  logic       rdata_valid;
  bus_rdata_t rdata;
  logic       rdata_ready;

  mem_access_stage u_stage (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .rdata_o       (rdata_o),
    .wreq_valid_o  (wreq_valid),
    .wreq_o        (wreq),
    .wreq_ready_i  (wreq_ready),
    .bresp_valid_i (bresp_valid),
    .bresp_ready_o (bresp_ready),
    .rreq_valid_o  (rreq_valid),
    .rreq_o        (rreq),
    .rreq_ready_i  (rreq_ready),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (rdata),
    .rdata_ready_o (rdata_ready)
  );

  data_ram u_ram (
    .clk           (clk),
    .reset_i       (reset_i),
    .wreq_valid_i  (wreq_valid),
    .wreq_i        (wreq),
    .wreq_ready_o  (wreq_ready),
    .bresp_valid_o (bresp_valid),
    .bresp_ready_i (bresp_ready),
    .rreq_valid_i  (rreq_valid),
    .rreq_i        (rreq),
    .rreq_ready_o  (rreq_ready),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata),
    .rdata_ready_i (rdata_ready)
  );

endmodule

// ==== dv/mem_subsys_asserts.sv ====
// bus protocol and alignment checks bound into every mem_access_stage instance
`timescale 1ns/1ps

module mem_subsys_asserts
  import lsu_pkg::*, bus_pkg::*;
(
  input logic       clk,
  input logic       reset_i,
  input logic       req_valid_i,
  input lsu_req_t   req_i,
  input logic       busy_o,
  input logic       done_o,
  input logic       wreq_valid_o,
  input bus_wreq_t  wreq_o,
  input logic       wreq_ready_i,
  input logic       bresp_valid_i,
  input logic       bresp_ready_o,
  input logic       rreq_valid_o,
  input bus_rreq_t  rreq_o,
  input logic       rreq_ready_i,
  input logic       rdata_valid_i,
  input bus_rdata_t rdata_i,
  input logic       rdata_ready_o
);

  logic [2:0] align_mask; // low address bits that must be zero
  int         fail_count = 0; // assertion failures so far

  always_comb begin
    case (req_i.size)
      2'd0:    align_mask = 3'b000;
      2'd1:    align_mask = 3'b001;
      2'd2:    align_mask = 3'b011;
      default: align_mask = 3'b111;
    endcase
  end

  a_wreq_hold: assert property (@(posedge clk) disable iff (reset_i)
    wreq_valid_o && !wreq_ready_i |=> wreq_valid_o && $stable(wreq_o))
    else begin
      $error("write request changed before its handshake");
      fail_count++;
    end

  a_rreq_hold: assert property (@(posedge clk) disable iff (reset_i)
    rreq_valid_o && !rreq_ready_i |=> rreq_valid_o && $stable(rreq_o))
    else begin
      $error("read request changed before its handshake");
      fail_count++;
    end

  a_bresp_hold: assert property (@(posedge clk) disable iff (reset_i)
    bresp_valid_i && !bresp_ready_o |=> bresp_valid_i)
    else begin
      $error("write response dropped before its handshake");
      fail_count++;
    end

  a_rdata_hold: assert property (@(posedge clk) disable iff (reset_i)
    rdata_valid_i && !rdata_ready_o |=> rdata_valid_i && $stable(rdata_i))
    else begin
      $error("read data changed before its handshake");
      fail_count++;
    end

  a_aligned: assert property (@(posedge clk) disable iff (reset_i)
    req_valid_i && !busy_o |-> (req_i.addr[2:0] & align_mask) == 3'b000)
    else begin
      $error("accepted access is not aligned to its size");
      fail_count++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
    done_o |=> !done_o)
    else begin
      $error("done held longer than one cycle");
      fail_count++;
    end

  // first edge out of reset
  a_reset_idle: assert property (@(posedge clk)
    $fell(reset_i) |-> !busy_o && !done_o && !wreq_valid_o && !rreq_valid_o)
    else begin
      $error("stage not idle after reset");
      fail_count++;
    end

endmodule

bind mem_access_stage mem_subsys_asserts i_asserts (.*);

// ==== dv/mem_subsys_tb.sv ====
// directed testbench that runs the memory subsystem with mem_subsys_tb as top module
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_tb
  import lsu_pkg::*;
();

  localparam int acc_cycles  = `MEM_LATENCY + 3; // accept to done
  localparam int done_wait   = 20;
  localparam int cycle_limit = 6000;
  localparam int mem_bytes   = `MEM_WORDS * 8;

  logic       clk;
  logic       reset;
  logic       req_valid;
  lsu_req_t   req;
  logic       busy;
  logic       done;
  xlen_t      rdata;

  logic [7:0] model_mem [mem_bytes]; // byte image of the ram
  integer     seed;
  int         err_count;
  int         errs_before;
  int         n_tests;
  int         n_failed;
  int         n_assert;
  int         cycle_count;
  string      cur_test;

  mem_subsys_top i_mem_subsys_top (
    .clk         (clk),
    .reset_i     (reset),
    .req_valid_i (req_valid),
    .req_i       (req),
    .busy_o      (busy),
    .done_o      (done),
    .rdata_o     (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic lsu_req_t make_req(logic st, logic sx, lsu_size_t sz, addr_t a, xlen_t d);
    return '{st, sx, sz, a, d};
  endfunction

  function automatic void model_store(addr_t a, lsu_size_t sz, xlen_t d);
    for (int b = 0; b < (1 << sz); b++) begin
      model_mem[(a + b) % mem_bytes] = d[8*b +: 8];
    end
  endfunction

  // addressed bytes with sign or zero fill above them
  function automatic xlen_t model_load(addr_t a, lsu_size_t sz, logic sext);
    xlen_t v;
    int    nb;
    nb = 1 << sz;
    v  = '0;
    for (int b = 0; b < nb; b++) begin
      v[8*b +: 8] = model_mem[(a + b) % mem_bytes];
    end
    if (sext && v[8*nb-1]) begin
      for (int i = 8 * nb; i < `MEM_XLEN; i++) v[i] = 1'b1;
    end
    return v;
  endfunction

  task automatic check_word(string what, xlen_t exp, xlen_t act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // called 1 ns after the accepting edge
  task automatic wait_done(output int lat);
    lat = 0;
    while (!done && lat < done_wait) begin
      @(posedge clk);
      #1;
      lat++;
      if (!done) check_flag("busy while waiting", 1'b1, busy);
    end
    if (!done) begin
      $display("%s: done_o did not arrive within %0d cycles", cur_test, done_wait);
      err_count++;
    end else begin
      check_flag("busy in done cycle", 1'b0, busy);
    end
  endtask

  task automatic run_access(input lsu_req_t r, output int lat);
    req       = r;
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    check_flag("busy after accept", 1'b1, busy);
    wait_done(lat);
  endtask

  // applies a finished access to the model and checks loads
  task automatic retire(lsu_req_t r);
    if (r.is_store) begin
      model_store(r.addr, r.size, r.wdata);
    end else begin
      check_word($sformatf("load %h size %0d sext %b", r.addr, r.size, r.sign_ext),
                 model_load(r.addr, r.size, r.sign_ext), rdata);
    end
  endtask

  task automatic access(lsu_req_t r);
    int lat;
    run_access(r, lat);
    retire(r);
  endtask

  // second request stays on the inputs while the first one runs
  task automatic held_pair(lsu_req_t first, lsu_req_t second);
    int lat;
    req       = first;
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req = second;
    wait_done(lat);
    retire(first);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    check_flag("held request taken", 1'b1, busy);
    wait_done(lat);
    retire(second);
  endtask

  task automatic test_reset();
    int lat;
    check_flag("busy after reset", 1'b0, busy);
    check_flag("done after reset", 1'b0, done);
    check_word("rdata after reset", '0, rdata);
    run_access(make_req(1'b1, 1'b0, 2'd3, 32'h40, 64'h0123_4567_89ab_cdef), lat);
    model_store(32'h40, 2'd3, 64'h0123_4567_89ab_cdef);
    check_word("store cycles", xlen_t'(acc_cycles), xlen_t'(lat));
    run_access(make_req(1'b0, 1'b0, 2'd3, 32'h40, '0), lat);
    check_word("load cycles", xlen_t'(acc_cycles), xlen_t'(lat));
    check_word("load data", 64'h0123_4567_89ab_cdef, rdata);
    @(posedge clk);
    #1;
    check_flag("done one cycle", 1'b0, done);
  endtask

  task automatic test_dword();
    addr_t a;
    for (int i = 0; i < 8; i++) begin
      a = 32'h80 + 24 * i;
      access(make_req(1'b1, 1'b0, 2'd3, a, {~a, a ^ 32'h1357_9bdf}));
    end
    for (int i = 0; i < 8; i++) access(make_req(1'b0, 1'b0, 2'd3, 32'h80 + 24 * i, '0));
  endtask

  task automatic test_merge();
    access(make_req(1'b1, 1'b0, 2'd3, 32'h200, 64'h1122_3344_5566_7788));
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        access(make_req(1'b1, 1'b0, lsu_size_t'(sz), 32'h200 + off,
                        {$random(seed), $random(seed)})); // upper bytes are junk
        access(make_req(1'b0, 1'b0, 2'd3, 32'h200, '0));
      end
    end
  endtask

  task automatic test_extend();
    xlen_t pat [2] = '{64'h7f01_2233_4455_6677, 64'h80f1_92a3_b4c5_d6e7};
    for (int p = 0; p < 2; p++) begin
      access(make_req(1'b1, 1'b0, 2'd3, 32'h300, pat[p]));
      for (int sz = 0; sz < 4; sz++) begin
        for (int off = 0; off < 8; off += (1 << sz)) begin
          for (int sx = 0; sx < 2; sx++) begin
            access(make_req(1'b0, 1'(sx), lsu_size_t'(sz), 32'h300 + off, '0));
          end
        end
      end
    end
  endtask

  task automatic test_busy();
    access(make_req(1'b1, 1'b0, 2'd3, 32'h380, 64'h0a0b_0c0d_0e0f_1011));
    held_pair(make_req(1'b0, 1'b0, 2'd3, 32'h380, '0),
              make_req(1'b1, 1'b0, 2'd3, 32'h380, 64'hfeed_face_cafe_beef));
    held_pair(make_req(1'b1, 1'b0, 2'd2, 32'h384, 64'h9234_5678),
              make_req(1'b0, 1'b1, 2'd3, 32'h380, '0));
    access(make_req(1'b0, 1'b1, 2'd2, 32'h384, '0));
  endtask

  task automatic test_random();
    lsu_req_t r;
    addr_t    a;
    int       off;
    for (int w = 0; w < 16; w++) begin
      a = 32'h400 + 8 * w;
      access(make_req(1'b1, 1'b0, 2'd3, a, {a ^ 32'hc3a5_0f96, ~a}));
    end
    for (int n = 0; n < 200; n++) begin
      r.size     = lsu_size_t'($random(seed));
      r.is_store = 1'($random(seed));
      r.sign_ext = 1'($random(seed));
      off        = $random(seed) & 7;
      off        = off & ~((1 << r.size) - 1); // natural alignment
      r.addr     = 32'h400 + addr_t'(8 * ($random(seed) & 15) + off);
      r.wdata    = {$random(seed), $random(seed)};
      access(r);
    end
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    errs_before = err_count;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_count == errs_before) begin
      $display("test %s: ok", cur_test);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", cur_test, err_count - errs_before);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped after %0d cycles without finishing", cycle_limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed      = 48680;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    err_count = 0;
    n_tests   = 0;
    n_failed  = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test("reset_state");
    test_reset();
    end_test();
    begin_test("dword_round_trip");
    test_dword();
    end_test();
    begin_test("strobe_merge");
    test_merge();
    end_test();
    begin_test("load_extension");
    test_extend();
    end_test();
    begin_test("busy_ignore");
    test_busy();
    end_test();
    begin_test("random_mix");
    test_random();
    end_test();

    n_assert = i_mem_subsys_top.u_stage.i_asserts.fail_count;
    $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
             n_tests, n_failed, err_count, n_assert);
    if (err_count == 0 && n_assert == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+design
design/lsu_pkg.sv
design/bus_pkg.sv
design/mem_access_stage.sv
design/data_ram.sv
design/mem_subsys_top.sv
dv/mem_subsys_asserts.sv
dv/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/bus_pkg.sv
      - design/mem_access_stage.sv
      - design/data_ram.sv
      - design/mem_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/mem_subsys_asserts.sv
      - dv/mem_subsys_tb.sv
